//--- sources.f
+incdir+.
obi_pkg.sv
obi_if.sv
obi_lsu_master.sv
obi_sram_slave.sv
obi_mem_top.sv
obi_asserts.sv
tb_obi_checker.sv
tb_obi_mem.sv

//--- Makefile
# Verilator build of the OBI memory subsystem testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module tb_obi_mem -f sources.f -o sim_obi_mem

# The run passes only when the pass line shows up in the simulator output
run: compile
	@out=$$(./obj_dir/sim_obi_mem); echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

//--- tb_obi_mem.sv
// ------------------
// Testbench for the OBI memory subsystem, table-driven loads and stores
// ------------------
`timescale 1ns/1ps
`include "obi_macros.svh"

module tb_obi_mem;
  import obi_pkg::*;

  localparam int N_DIRECTED = 16;
  localparam int N_RANDOM   = 16;
  localparam int N_ENTRIES  = N_DIRECTED + N_RANDOM;
  localparam int MAX_STALL  = 5;
  localparam int WATCHDOG_NS =
    (N_ENTRIES * (8 + MAX_STALL) + `OBI_RESET_CYCLES) * `OBI_CLK_PERIOD;

  // One host command with its stall count and expected outcome
  typedef struct packed {
    logic       we;
    obi_addr_t  addr;
    obi_size_t  size;
    obi_data_t  wdata;
    logic [3:0] stall;
    obi_data_t  rdata;
    logic       mis;
  } entry_t;

  entry_t     stim [N_ENTRIES];
  logic [7:0] shadow [1 << `OBI_ADDR_W];

  logic       clk;
  logic       reset_n;
  logic       start;
  logic       cmd_we;
  obi_addr_t  cmd_addr;
  obi_size_t  cmd_size;
  obi_data_t  cmd_wdata;
  logic       gnt_stall;
  logic       busy;
  logic       done;
  logic       misaligned;
  obi_data_t  rsp_rdata;
  logic       exp_we;
  logic       exp_mis;
  obi_data_t  exp_rdata;
  logic [7:0] exp_lat;
  int         pass_count;
  int         fail_count;
  int         tests_done;

  obi_mem_top DUT (
    .clk (clk), .reset_n (reset_n), .start (start), .cmd_we (cmd_we),
    .cmd_addr (cmd_addr), .cmd_size (cmd_size), .cmd_wdata (cmd_wdata),
    .gnt_stall (gnt_stall), .busy (busy), .done (done),
    .misaligned (misaligned), .rsp_rdata (rsp_rdata)
  );

  tb_obi_checker u_checker (
    .clk (clk), .reset_n (reset_n), .start (start), .busy (busy), .done (done),
    .misaligned (misaligned), .rsp_rdata (rsp_rdata), .exp_we (exp_we),
    .exp_mis (exp_mis), .exp_rdata (exp_rdata), .exp_lat (exp_lat),
    .pass_count (pass_count), .fail_count (fail_count), .tests_done (tests_done)
  );

  initial clk = 1'b0;
  always #(`OBI_CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic entry_t make_entry(input logic we, input obi_addr_t addr,
                                        input obi_size_t size, input obi_data_t wdata,
                                        input logic [3:0] stall, input obi_data_t rdata,
                                        input logic mis);
    entry_t e;
    e = '{we: we, addr: addr, size: size, wdata: wdata, stall: stall, rdata: rdata, mis: mis};
    return e;
  endfunction

  // --------------------
  // Directed rows first, then random word stores and their reloads
  task automatic build_table();
    logic [31:0] seed;
    obi_addr_t   ra [N_RANDOM / 2];
    obi_data_t   rd;
    obi_addr_t   a;
    int          j;
    stim[0]  = make_entry(1'b1, 12'h100, 2'd2, 32'hdeadbeef, 4'd0, 32'h0, 1'b0);
    stim[1]  = make_entry(1'b0, 12'h100, 2'd2, 32'h0, 4'd0, 32'hdeadbeef, 1'b0);
    // Lanes of one word built up from byte and halfword stores
    stim[2]  = make_entry(1'b1, 12'h200, 2'd0, 32'ha5a5a511, 4'd0, 32'h0, 1'b0);
    stim[3]  = make_entry(1'b1, 12'h201, 2'd0, 32'h00000022, 4'd0, 32'h0, 1'b0);
    stim[4]  = make_entry(1'b1, 12'h202, 2'd1, 32'h00004433, 4'd0, 32'h0, 1'b0);
    stim[5]  = make_entry(1'b0, 12'h200, 2'd2, 32'h0, 4'd0, 32'h44332211, 1'b0);
    stim[6]  = make_entry(1'b0, 12'h203, 2'd0, 32'h0, 4'd0, 32'h00000044, 1'b0);
    stim[7]  = make_entry(1'b0, 12'h202, 2'd1, 32'h0, 4'd0, 32'h00004433, 1'b0);
    stim[8]  = make_entry(1'b0, 12'h201, 2'd0, 32'h0, 4'd0, 32'h00000022, 1'b0);
    // Rejected commands, then proof that word 0x100 kept its value
    stim[9]  = make_entry(1'b1, 12'h101, 2'd1, 32'h00005555, 4'd0, 32'h0, 1'b1);
    stim[10] = make_entry(1'b1, 12'h102, 2'd2, 32'h12345678, 4'd0, 32'h0, 1'b1);
    stim[11] = make_entry(1'b0, 12'h100, 2'd3, 32'h0, 4'd0, 32'h0, 1'b1);
    stim[12] = make_entry(1'b0, 12'h100, 2'd2, 32'h0, 4'd0, 32'hdeadbeef, 1'b0);
    // Back-pressure on the address phase
    stim[13] = make_entry(1'b1, 12'h300, 2'd2, 32'h0badf00d, 4'd2, 32'h0, 1'b0);
    stim[14] = make_entry(1'b0, 12'h300, 2'd2, 32'h0, 4'd5, 32'h0badf00d, 1'b0);
    stim[15] = make_entry(1'b0, 12'h301, 2'd0, 32'h0, 4'd1, 32'h000000f0, 1'b0);
    seed = 32'hb2f8;
    for (int k = 0; k < N_RANDOM / 2; k++) begin
      seed  = lcg_next(seed);
      ra[k] = {seed[`OBI_ADDR_W+1:4], 2'b00};
      seed  = lcg_next(seed);
      rd    = seed;
      seed  = lcg_next(seed);
      stim[N_DIRECTED + k] = make_entry(1'b1, ra[k], 2'd2, rd, {2'b00, seed[17:16]}, 32'h0, 1'b0);
      // Shadow keeps the byte lanes of a word store
      for (int b = 0; b < 4; b++) begin
        shadow[{ra[k][`OBI_ADDR_W-1:2], 2'(b)}] = rd[8*b +: 8];
      end
    end
    // Reloads run after every store, so the shadow already holds the last writer
    j = N_DIRECTED + N_RANDOM / 2;
    for (int k = N_RANDOM / 2 - 1; k >= 0; k--) begin
      seed = lcg_next(seed);
      a    = ra[k];
      rd   = {shadow[{a[`OBI_ADDR_W-1:2], 2'd3}], shadow[{a[`OBI_ADDR_W-1:2], 2'd2}],
              shadow[{a[`OBI_ADDR_W-1:2], 2'd1}], shadow[{a[`OBI_ADDR_W-1:2], 2'd0}]};
      stim[j] = make_entry(1'b0, a, 2'd2, 32'h0, {2'b00, seed[17:16]}, rd, 1'b0);
      j++;
    end
  endtask

  task automatic release_reset();
    repeat (`OBI_RESET_CYCLES) @(posedge clk);
    reset_n <= 1'b1;
    repeat (2) @(posedge clk);
  endtask

  // Grant is combinational from gnt_stall, so the stall goes up with start
  // and req then waits exactly stall cycles before the accepting edge
  task automatic apply_entry(input int idx);
    entry_t e;
    int     base;
    int     stall_n;
    e       = stim[idx];
    base    = tests_done;
    stall_n = int'(e.stall);
    @(posedge clk);
    start     <= 1'b1;
    cmd_we    <= e.we;
    cmd_addr  <= e.addr;
    cmd_size  <= e.size;
    cmd_wdata <= e.wdata;
    gnt_stall <= (e.stall != 4'd0);
    exp_we    <= e.we;
    exp_mis   <= e.mis;
    exp_rdata <= e.rdata;
    exp_lat   <= e.mis ? 8'd1 : 8'd3 + {4'h0, e.stall};
    @(posedge clk);
    start <= 1'b0;
    for (int s = 0; s < stall_n; s++) @(posedge clk);
    gnt_stall <= 1'b0;
    // The checker closes the test on done or on its own done timeout
    while (tests_done == base) @(posedge clk);
  endtask

  initial begin
    reset_n   = 1'b0;
    start     = 1'b0;
    cmd_we    = 1'b0;
    cmd_addr  = '0;
    cmd_size  = '0;
    cmd_wdata = '0;
    gnt_stall = 1'b0;
    exp_we    = 1'b0;
    exp_mis   = 1'b0;
    exp_rdata = '0;
    exp_lat   = '0;
    build_table();
    release_reset();
    for (int i = 0; i < N_ENTRIES; i++) apply_entry(i);
    repeat (2) @(posedge clk);
    $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0 && tests_done == N_ENTRIES) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the table length and the worst stall
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- tb_obi_checker.sv
// ------------------
// Completion checker, compares each done against the expected table row
// ------------------
`timescale 1ns/1ps

module tb_obi_checker (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               start,
  input  logic               busy,
  input  logic               done,
  input  logic               misaligned,
  input  obi_pkg::obi_data_t rsp_rdata,
  input  logic               exp_we,
  input  logic               exp_mis,
  input  obi_pkg::obi_data_t exp_rdata,
  input  logic [7:0]         exp_lat,
  output int                 pass_count,
  output int                 fail_count,
  output int                 tests_done
);
  import obi_pkg::*;

  // Extra cycles past the expected latency before done counts as lost
  localparam int DONE_SLACK = 4;

  logic      pending;
  logic      reset_seen;
  logic      busy_lost;
  logic      we_q;
  logic      mis_q;
  obi_data_t rdata_q;
  int        lat_q;
  int        cycles;

  always @(posedge clk or negedge reset_n) begin : watch
    logic bad;
    if (!reset_n) begin
      pending    <= 1'b0;
      reset_seen <= 1'b0;
      busy_lost  <= 1'b0;
      cycles     <= 0;
      pass_count <= 0;
      fail_count <= 0;
      tests_done <= 0;
    end else begin
      bad = 1'b0;
      // --------------------
      // First edge out of reset, all host outputs must be idle
      if (!reset_seen) begin
        reset_seen <= 1'b1;
        if ({busy, done, misaligned} != 3'b000 || rsp_rdata != '0) begin
          $display("** Error reset: busy done misaligned rsp_rdata expected 0 0 0 0, %s",
                   $sformatf("got %h %h %h %h", busy, done, misaligned, rsp_rdata));
          fail_count <= fail_count + 1;
        end else begin
          $display("reset check ok");
          pass_count <= pass_count + 1;
        end
      end else if (pending && done) begin
        if (misaligned != mis_q) begin
          $display("** Error test %0d: misaligned expected %h, got %h",
                   tests_done, mis_q, misaligned);
          bad = 1'b1;
        end
        if (cycles != lat_q) begin
          $display("** Error test %0d: done latency expected 'h%0h, got 'h%0h",
                   tests_done, lat_q, cycles);
          bad = 1'b1;
        end
        if (busy_lost) begin
          $display("** Error test %0d: busy expected 1, got 0 before done", tests_done);
          bad = 1'b1;
        end
        // Only a completed load carries data worth comparing
        if (!we_q && !mis_q && rsp_rdata != rdata_q) begin
          $display("** Error test %0d: rsp_rdata expected %h, got %h",
                   tests_done, rdata_q, rsp_rdata);
          bad = 1'b1;
        end
        $display("test %0d %s", tests_done, bad ? "failed" : "ok");
        if (bad) fail_count <= fail_count + 1;
        else pass_count <= pass_count + 1;
        pending    <= 1'b0;
        tests_done <= tests_done + 1;
      end else if (pending && cycles > lat_q + DONE_SLACK) begin
        $display("test %0d failed: done never came, %0d cycles after start", tests_done, cycles);
        fail_count <= fail_count + 1;
        pending    <= 1'b0;
        tests_done <= tests_done + 1;
      end else if (pending) begin
        cycles <= cycles + 1;
        // busy covers the whole command from the cycle after start until done
        if (!busy) begin
          busy_lost <= 1'b1;
        end
      end else if (done) begin
        $display("Unexpected done while no command was in flight");
        fail_count <= fail_count + 1;
      end
      // Latch the expected row at the edge where the DUT takes start
      if (start && !busy) begin
        pending   <= 1'b1;
        busy_lost <= 1'b0;
        cycles    <= 1;
        we_q      <= exp_we;
        mis_q     <= exp_mis;
        rdata_q   <= exp_rdata;
        lat_q     <= int'(exp_lat);
      end
    end
  end

endmodule

//--- obi_asserts.sv
// ------------------
// OBI A/R protocol checks, bound to the SRAM slave
// ------------------
`timescale 1ns/1ps

module obi_asserts (
  input logic               clk,
  input logic               reset_n,
  input logic               req,
  input logic               gnt,
  input logic               we,
  input logic               rvalid,
  input obi_pkg::obi_addr_t addr,
  input obi_pkg::obi_be_t   be,
  input obi_pkg::obi_data_t wdata
);
  import obi_pkg::*;

  // Accepted phases still waiting for their rvalid
  logic [1:0] outstanding;

  // Legal lane patterns, one run of ones with no holes
  function automatic logic be_contiguous(input obi_be_t b);
    case (b)
      4'b0001, 4'b0010, 4'b0100, 4'b1000: return 1'b1;
      4'b0011, 4'b0110, 4'b1100: return 1'b1;
      4'b0111, 4'b1110, 4'b1111: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [1:0] lowest_lane(input obi_be_t b);
    if (b[0]) return 2'd0;
    if (b[1]) return 2'd1;
    if (b[2]) return 2'd2;
    return 2'd3;
  endfunction

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      outstanding <= '0;
    end else begin
      outstanding <= outstanding + {1'b0, req && gnt} - {1'b0, rvalid};
    end
  end

  // --------------------
  a_phase_stable: assert property (@(posedge clk) disable iff (!reset_n)
    req && !gnt |=> $stable(addr) && $stable(we) && $stable(be) && $stable(wdata))
    else $error("OBI address phase changed while waiting for gnt");

  a_req_held: assert property (@(posedge clk) disable iff (!reset_n) req && !gnt |=> req)
    else $error("OBI req dropped before gnt");

  a_rvalid_outstanding: assert property (@(posedge clk) disable iff (!reset_n)
    rvalid |-> outstanding != 2'd0)
    else $error("OBI rvalid without an accepted address phase");

  a_be_contiguous: assert property (@(posedge clk) disable iff (!reset_n)
    req |-> be_contiguous(be))
    else $error("OBI be is zero or has a hole");

  a_addr_lsb: assert property (@(posedge clk) disable iff (!reset_n)
    req |-> addr[1:0] <= lowest_lane(be))
    else $error("OBI addr lane bits lie above the lowest enabled lane");

endmodule

bind obi_sram_slave obi_asserts u_asserts (
  .clk     (clk),
  .reset_n (reset_n),
  .req     (bus.req),
  .gnt     (bus.gnt),
  .we      (bus.we),
  .rvalid  (bus.rvalid),
  .addr    (bus.addr),
  .be      (bus.be),
  .wdata   (bus.wdata)
);

//--- obi_mem_top.sv
// ------------------
// OBI memory subsystem top, LSU master joined to the SRAM slave
// ------------------
`timescale 1ns/1ps

module obi_mem_top (
  input  logic               clk,
  input  logic               reset_n,
  // Host command
  input  logic               start,
  input  logic               cmd_we,
  input  obi_pkg::obi_addr_t cmd_addr,
  input  obi_pkg::obi_size_t cmd_size,
  input  obi_pkg::obi_data_t cmd_wdata,
  // Slave back-pressure
  input  logic               gnt_stall,
  // Host result
  output logic               busy,
  output logic               done,
  output logic               misaligned,
  output obi_pkg::obi_data_t rsp_rdata
);

  // Internal OBI A/R bus
  obi_if bus ();

  obi_lsu_master u_master (
    .clk        (clk),
    .reset_n    (reset_n),
    .start      (start),
    .cmd_we     (cmd_we),
    .cmd_addr   (cmd_addr),
    .cmd_size   (cmd_size),
    .cmd_wdata  (cmd_wdata),
    .busy       (busy),
    .done       (done),
    .misaligned (misaligned),
    .rsp_rdata  (rsp_rdata),
    .bus        (bus.master)
  );

  obi_sram_slave u_sram (
    .clk       (clk),
    .reset_n   (reset_n),
    .gnt_stall (gnt_stall),
    .bus       (bus.slave)
  );

endmodule

//--- obi_sram_slave.sv
// ------------------
// OBI SRAM slave
// Byte-enabled word memory with stall-driven gnt and one-cycle response
// ------------------
`timescale 1ns/1ps
`include "obi_macros.svh"

module obi_sram_slave (
  input logic   clk,
  input logic   reset_n,
  input logic   gnt_stall,
  obi_if.slave  bus
);
  import obi_pkg::*;

  // Word index width, the byte address without its two lane bits
  localparam int unsigned IDX_W = `OBI_ADDR_W - 2;

  // ------------------
  // Storage and state
  // ------------------
  // Word array, indexed by address bits above bit 1
  obi_data_t mem [`OBI_MEM_WORDS];

  logic [IDX_W-1:0] word_idx;
  logic             accept;
  logic             rvalid_q;
  obi_data_t        rdata_q;

  // ------------------
  // Address phase
  // ------------------
  // Grant follows the stall level directly, with or without req
  // so the slave never stores a pending request of its own
  assign bus.gnt = ~gnt_stall;

  // An address phase completes in the cycle with req and gnt both high
  assign accept = bus.req && bus.gnt;

  // Lane bits are dropped, the byte enables select the bytes
  assign word_idx = bus.addr[`OBI_ADDR_W-1:2];

  // Stores commit at the accepting edge, one byte lane at a time
  // Loads capture the whole word, the master picks its lanes
  always_ff @(posedge clk) begin
    if (accept) begin
      if (bus.we) begin
        for (int lane = 0; lane < 4; lane++) begin
          if (bus.be[lane]) begin
            mem[word_idx][8*lane +: 8] <= bus.wdata[8*lane +: 8];
          end
        end
      end else begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  // ------------------
  // Response phase
  // ------------------
  // rvalid is high for exactly the cycle after each accepted phase
  // Back-to-back accepts would give back-to-back pulses
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= accept;
    end
  end

  // On a store rdata still shows the last loaded word
  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;

endmodule

//--- obi_lsu_master.sv
// ------------------
// OBI LSU master
// Turns one host load/store command into one OBI transaction
// ------------------
`timescale 1ns/1ps

module obi_lsu_master (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               start,
  input  logic               cmd_we,
  input  obi_pkg::obi_addr_t cmd_addr,
  input  obi_pkg::obi_size_t cmd_size,
  input  obi_pkg::obi_data_t cmd_wdata,
  output logic               busy,
  output logic               done,
  output logic               misaligned,
  output obi_pkg::obi_data_t rsp_rdata,
  obi_if.master              bus
);
  import obi_pkg::*;

  lsu_state_t state;

  // Address phase registers, frozen from issue until gnt
  obi_addr_t addr_q;
  obi_be_t   be_q;
  obi_data_t wdata_q;
  logic      we_q;
  obi_size_t size_q;

  logic      cmd_aligned;
  obi_be_t   cmd_be;
  obi_data_t cmd_lanes;
  logic      issue;
  logic      accept;
  obi_data_t load_shifted;
  obi_data_t load_value;

  // ------------------
  // Command decode
  // ------------------
  // Alignment check, byte enables and store lane replication
  // Word access keeps the defaults of all lanes and the raw data
  always_comb begin
    cmd_aligned = 1'b0;
    cmd_be      = 4'b1111;
    cmd_lanes   = cmd_wdata;
    case (cmd_size)
      2'd0: begin
        cmd_aligned = 1'b1;
        cmd_be      = 4'b0001 << cmd_addr[1:0];
        cmd_lanes   = {4{cmd_wdata[7:0]}};
      end
      2'd1: begin
        cmd_aligned = ~cmd_addr[0];
        cmd_be      = 4'b0011 << {cmd_addr[1], 1'b0};
        cmd_lanes   = {2{cmd_wdata[15:0]}};
      end
      2'd2: begin
        cmd_aligned = (cmd_addr[1:0] == 2'b00);
      end
      default: begin
        // Size 3 has no legal encoding and is reported as misaligned
        cmd_aligned = 1'b0;
      end
    endcase
  end

  // A command goes on the bus only when it arrives in idle and is aligned
  assign issue  = (state == LSU_IDLE) && start && cmd_aligned;
  assign accept = bus.req && bus.gnt;

  // Load lanes are moved down to bit 0 and zero-extended by size
  always_comb begin
    load_shifted = bus.rdata >> {addr_q[1:0], 3'b000};
    case (size_q)
      2'd0:    load_value = {24'h0, load_shifted[7:0]};
      2'd1:    load_value = {16'h0, load_shifted[15:0]};
      default: load_value = load_shifted;
    endcase
  end

  // ------------------
  // Phase registers and FSM
  // ------------------
  always_ff @(posedge clk) begin
    if (issue) begin
      addr_q  <= cmd_addr;
      be_q    <= cmd_be;
      wdata_q <= cmd_lanes;
      we_q    <= cmd_we;
      size_q  <= cmd_size;
    end
  end

  // done and misaligned are one-cycle pulses, cleared by default
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state      <= LSU_IDLE;
      done       <= 1'b0;
      misaligned <= 1'b0;
      rsp_rdata  <= '0;
    end else begin
      done       <= 1'b0;
      misaligned <= 1'b0;
      case (state)
        LSU_IDLE: begin
          if (issue) begin
            state <= LSU_ADDR;
          end else if (start) begin
            // Rejected without touching the bus
            done       <= 1'b1;
            misaligned <= 1'b1;
          end
        end
        LSU_ADDR: begin
          if (accept) begin
            state <= LSU_RESP;
          end
        end
        LSU_RESP: begin
          if (bus.rvalid) begin
            state <= LSU_IDLE;
            done  <= 1'b1;
            // Stores leave the last load value in place
            if (!we_q) begin
              rsp_rdata <= load_value;
            end
          end
        end
        default: state <= LSU_IDLE;
      endcase
    end
  end

  // req is the state itself, so it cannot drop before gnt
  assign bus.req   = (state == LSU_ADDR);
  assign bus.addr  = addr_q;
  assign bus.we    = we_q;
  assign bus.be    = be_q;
  assign bus.wdata = wdata_q;
  assign busy      = (state != LSU_IDLE);

endmodule

//--- obi_if.sv
// ------------------
// OBI A/R channel bundle between LSU master and SRAM slave
// ------------------
`timescale 1ns/1ps

interface obi_if;
  import obi_pkg::*;

  // Address phase, driven by the master
  logic      req;
  obi_addr_t addr;
  logic      we;
  obi_be_t   be;
  obi_data_t wdata;

  // Grant, driven by the slave and free to toggle even with req low
  logic gnt;

  // Response phase, one rvalid pulse per accepted address phase
  logic      rvalid;
  obi_data_t rdata;

  // Requester side
  modport master (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata
  );

  // Memory side, mirror of the master
  modport slave (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata
  );

endinterface

//--- obi_pkg.sv
// ------------------
// OBI memory subsystem types
// ------------------
`include "obi_macros.svh"

package obi_pkg;

  // Byte address as carried on the OBI address phase
  typedef logic [`OBI_ADDR_W-1:0] obi_addr_t;

  // One 32-bit data word, four byte lanes
  typedef logic [31:0] obi_data_t;

  // One enable bit per byte lane
  typedef logic [3:0] obi_be_t;

  // Access size of a host command
  // 0 is byte, 1 is halfword, 2 is word, 3 is always rejected
  typedef logic [1:0] obi_size_t;

  // Master FSM
  // LSU_ADDR holds the address phase until gnt
  // LSU_RESP waits for the single rvalid of the transaction
  typedef enum logic [1:0] {
    LSU_IDLE,
    LSU_ADDR,
    LSU_RESP
  } lsu_state_t;

endpackage

//--- obi_macros.svh
// ------------------
// OBI memory subsystem constants shared by the RTL and the bench
// ------------------
`ifndef OBI_MACROS_SVH
`define OBI_MACROS_SVH

// Byte address width of the OBI bus
`define OBI_ADDR_W 12

// Depth of the SRAM in 32-bit words
// Must equal 2 ** (OBI_ADDR_W - 2)
`define OBI_MEM_WORDS 1024

// Bench clock period in timescale units
`define OBI_CLK_PERIOD 100

// Number of clock cycles the bench holds reset_n low
`define OBI_RESET_CYCLES 10

`endif
